/* design/x86_exec_defines.svh */
`ifndef X86_EXEC_DEFINES_SVH
`define X86_EXEC_DEFINES_SVH

// Datapath width
`define DATA_W 32

// --------------------
// EFLAGS bit positions
// --------------------
`define CF_BIT 0
`define PF_BIT 2
`define AF_BIT 4
`define ZF_BIT 6
`define SF_BIT 7
`define DF_BIT 10
`define OF_BIT 11

// Only reserved bit 1 set out of reset
`define EFLAGS_RESET 32'h0000_0002

`endif

/* design/x86_exec_pkg.sv */
package x86_exec_pkg;

	// --------------------
	// Opcodes, 3-bit field
	// --------------------
	typedef enum logic [2:0] {
		OP_ADD = 3'd0,
		OP_OR  = 3'd1,
		OP_NOT = 3'd2,
		OP_DAA = 3'd3,
		OP_AND = 3'd4,
		OP_CLD = 3'd5,
		OP_CMP = 3'd6,
		OP_STD = 3'd7
	} alu_op_e;

	// --------------------
	// Operand size
	// --------------------
	// Encoding 3 is not a legal size
	typedef enum logic [1:0] {
		SIZE_8  = 2'd0,
		SIZE_16 = 2'd1,
		SIZE_32 = 2'd2
	} data_size_e;

endpackage

/* design/alu_flag_logic.sv */
`include "x86_exec_defines.svh"

module alu_flag_logic (
	input  x86_exec_pkg::data_size_e size,
	input  logic [`DATA_W-1:0]        res,
	input  logic [`DATA_W-1:0]        a,
	input  logic [`DATA_W-1:0]        b,
	input  logic [`DATA_W:0]          carry,
	input  logic                      sub,
	output logic                      sf,
	output logic                      zf,
	output logic                      pf,
	output logic                      cf,
	output logic                      of,
	output logic                      af
);
	import x86_exec_pkg::*;

	// carry[i] is the carry into bit i, carry[DATA_W] the final carry out
	// a and b are the effective adder operands, b already inverted for subtract

	logic [`DATA_W-1:0] sized_res;
	logic               sign_res;
	logic               sign_a;
	logic               sign_b;
	logic               carry_out;

	// --------------------
	// Pick the sized slice
	// --------------------
	always_comb begin
		case (size)
			SIZE_8: begin
				sized_res = {24'b0, res[7:0]};
				sign_res  = res[7];
				sign_a    = a[7];
				sign_b    = b[7];
				carry_out = carry[8];
			end
			SIZE_16: begin
				sized_res = {16'b0, res[15:0]};
				sign_res  = res[15];
				sign_a    = a[15];
				sign_b    = b[15];
				carry_out = carry[16];
			end
			// 32-bit, also catches the illegal code
			default: begin
				sized_res = res;
				sign_res  = res[`DATA_W-1];
				sign_a    = a[`DATA_W-1];
				sign_b    = b[`DATA_W-1];
				carry_out = carry[`DATA_W];
			end
		endcase
	end

	// --------------------
	// Flag equations
	// --------------------
	assign sf = sign_res;
	assign zf = (sized_res == '0);
	// Even parity, low byte only
	assign pf = ~^res[7:0];
	// Subtract reports a borrow
	assign cf = carry_out ^ sub;
	// Same input signs, different result sign
	assign of = (sign_a == sign_b) && (sign_res != sign_a);
	// Nibble carry, borrow on subtract
	assign af = carry[4] ^ sub;

endmodule

/* design/alu_daa.sv */
module alu_daa (
	input  logic [7:0] al,
	input  logic       cf_in,
	input  logic       af_in,
	output logic [7:0] daa_result,
	output logic       cf,
	output logic       af
);

	// Decimal adjust of AL after a packed BCD add
	// Both decisions look at the original AL, not the partly adjusted one

	logic       low_fix;
	logic       high_fix;
	logic [7:0] al_low;

	// --------------------
	// Low digit
	// --------------------
	// Nibble above 9 or a half carry already out
	assign low_fix = (al[3:0] > 4'd9) || af_in;

	// Add 6 to skip the six unused codes
	assign al_low = low_fix ? (al + 8'h06) : al;

	// --------------------
	// High digit
	// --------------------
	// Whole byte above 99, or carry from the add
	assign high_fix = (al > 8'h99) || cf_in;

	assign daa_result = high_fix ? (al_low + 8'h60) : al_low;

	// --------------------
	// Flags
	// --------------------
	// Set exactly when the matching correction went in
	assign af = low_fix;
	assign cf = high_fix;

	// SF, ZF and PF come from the shared flag path in alu32

endmodule

/* design/alu32.sv */
`include "x86_exec_defines.svh"

module alu32 (
	input  x86_exec_pkg::alu_op_e    op,
	input  x86_exec_pkg::data_size_e size,
	input  logic [`DATA_W-1:0]        a,
	input  logic [`DATA_W-1:0]        b,
	input  logic                      cf_in,
	input  logic                      af_in,
	output logic [`DATA_W-1:0]        alu_result,
	output logic [`DATA_W-1:0]        new_flags,
	output logic                      dest_we_next
);
	import x86_exec_pkg::*;

	logic [`DATA_W-1:0] size_mask;
	logic [`DATA_W:0]   sum_full;
	logic [`DATA_W:0]   diff_full;
	logic [`DATA_W:0]   sum_carry;
	logic [`DATA_W:0]   diff_carry;
	logic [`DATA_W-1:0] b_minus_a;
	logic [`DATA_W-1:0] not_a;
	logic [`DATA_W-1:0] shared_res;
	data_size_e         shared_size;
	logic [7:0]         daa_al;
	logic               daa_cf;
	logic               daa_af;
	logic               add_sf, add_zf, add_pf, add_cf, add_of, add_af;
	logic               cmp_sf, cmp_zf, cmp_pf, cmp_cf, cmp_of, cmp_af;

	// Results are zero-extended to the operand size
	always_comb begin
		case (size)
			SIZE_8:  size_mask = 32'h0000_00ff;
			SIZE_16: size_mask = 32'h0000_ffff;
			default: size_mask = 32'hffff_ffff;
		endcase
	end

	// --------------------
	// Adders
	// --------------------
	assign sum_full = {1'b0, a} + {1'b0, b};
	// Compare takes b minus a
	assign not_a     = ~a;
	assign diff_full = {1'b0, b} + {1'b0, not_a} + 33'd1;
	assign b_minus_a = diff_full[`DATA_W-1:0];

	// Internal carries recovered from the sum bits
	assign sum_carry  = {sum_full[`DATA_W], a ^ b ^ sum_full[`DATA_W-1:0]};
	assign diff_carry = {diff_full[`DATA_W], b ^ not_a ^ b_minus_a};

	alu_daa u_alu_daa (
		.al         (a[7:0]),
		.cf_in      (cf_in),
		.af_in      (af_in),
		.daa_result (daa_al),
		.cf         (daa_cf),
		.af         (daa_af)
	);

	// Shared SF/ZF/PF path for ADD, logic ops and DAA
	always_comb begin
		shared_size = size;
		case (op)
			OP_OR:   shared_res = a | b;
			OP_AND:  shared_res = a & b;
			OP_DAA: begin
				shared_res  = {24'b0, daa_al};
				shared_size = SIZE_8;
			end
			default: shared_res = sum_full[`DATA_W-1:0];
		endcase
	end

	alu_flag_logic u_add_flags (
		.size  (shared_size),
		.res   (shared_res),
		.a     (a),
		.b     (b),
		.carry (sum_carry),
		.sub   (1'b0),
		.sf    (add_sf),
		.zf    (add_zf),
		.pf    (add_pf),
		.cf    (add_cf),
		.of    (add_of),
		.af    (add_af)
	);

	// Effective subtract operands so OF sees inverted a
	alu_flag_logic u_cmp_flags (
		.size  (size),
		.res   (b_minus_a),
		.a     (b),
		.b     (not_a),
		.carry (diff_carry),
		.sub   (1'b1),
		.sf    (cmp_sf),
		.zf    (cmp_zf),
		.pf    (cmp_pf),
		.cf    (cmp_cf),
		.of    (cmp_of),
		.af    (cmp_af)
	);

	// --------------------
	// Result and flag select
	// --------------------
	always_comb begin
		new_flags = '0;
		case (op)
			OP_ADD: begin
				alu_result            = sum_full[`DATA_W-1:0] & size_mask;
				new_flags[`OF_BIT]    = add_of;
				new_flags[`AF_BIT]    = add_af;
				new_flags[`CF_BIT]    = add_cf;
			end
			OP_OR, OP_AND: alu_result = shared_res & size_mask;
			OP_NOT:        alu_result = not_a & size_mask;
			OP_DAA: begin
				alu_result            = {24'b0, daa_al};
				new_flags[`AF_BIT]    = daa_af;
				new_flags[`CF_BIT]    = daa_cf;
			end
			OP_CMP: begin
				// Difference still reaches the result bus while dest_we stays low
				alu_result            = b_minus_a & size_mask;
				new_flags[`OF_BIT]    = cmp_of;
				new_flags[`SF_BIT]    = cmp_sf;
				new_flags[`ZF_BIT]    = cmp_zf;
				new_flags[`AF_BIT]    = cmp_af;
				new_flags[`PF_BIT]    = cmp_pf;
				new_flags[`CF_BIT]    = cmp_cf;
			end
			OP_STD: begin
				alu_result            = '0;
				new_flags[`DF_BIT]    = 1'b1;
			end
			// CLD leaves the DF candidate at zero
			default: alu_result = '0;
		endcase
		// Shared path feeds SF, ZF and PF of ADD, OR, AND and DAA
		if (op inside {OP_ADD, OP_OR, OP_AND, OP_DAA}) begin
			new_flags[`SF_BIT] = add_sf;
			new_flags[`ZF_BIT] = add_zf;
			new_flags[`PF_BIT] = add_pf;
		end
	end

	// Compare and DF ops leave the destination alone
	assign dest_we_next = !(op inside {OP_CMP, OP_CLD, OP_STD});

	// Sized ops would fall back to 32-bit flags on the bad code
	always_comb begin
		if (op inside {OP_ADD, OP_OR, OP_AND, OP_CMP})
			assert (size != SIZE_32 + 2'd1) else $error("alu32: illegal data size 3");
	end

endmodule

/* design/eflags_reg.sv */
`include "x86_exec_defines.svh"

module eflags_reg (
	input  logic                   clk,
	input  logic                   rst_n,
	input  logic                   op_valid,
	input  x86_exec_pkg::alu_op_e  op,
	input  logic [`DATA_W-1:0]     new_flags,
	output logic [`DATA_W-1:0]     eflags
);
	import x86_exec_pkg::*;

	// --------------------
	// Write masks
	// --------------------
	// Six status flags
	localparam logic [`DATA_W-1:0] STATUS_MASK = (1 << `OF_BIT) | (1 << `SF_BIT) |
		(1 << `ZF_BIT) | (1 << `AF_BIT) | (1 << `PF_BIT) | (1 << `CF_BIT);
	// Direction flag alone
	localparam logic [`DATA_W-1:0] DF_MASK = 1 << `DF_BIT;

	logic [`DATA_W-1:0] write_mask;
	logic [`DATA_W-1:0] eflags_next;

	// Bits an op clears arrive as zeros in new_flags
	// so OR, AND and DAA share the status mask with ADD and CMP
	always_comb begin
		case (op)
			OP_ADD, OP_CMP,
			OP_OR, OP_AND,
			OP_DAA:         write_mask = STATUS_MASK;
			OP_CLD, OP_STD: write_mask = DF_MASK;
			// NOT touches no flag
			default:        write_mask = '0;
		endcase
	end

	// Merge, bit 1 pinned high
	assign eflags_next = (eflags & ~write_mask) | (new_flags & write_mask) | `EFLAGS_RESET;

	// --------------------
	// Register
	// --------------------
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			eflags <= `EFLAGS_RESET;
		end else if (op_valid) begin
			eflags <= eflags_next;
		end
	end

	// Only the seven flags move, bit 1 always set
	a_reserved_bits: assert property (
		@(posedge clk) disable iff (!rst_n)
		(eflags & ~(STATUS_MASK | DF_MASK)) == `EFLAGS_RESET
	) else $error("eflags_reg: reserved bits corrupted");

endmodule

/* design/x86_exec.sv */
`include "x86_exec_defines.svh"

module x86_exec (
	input  logic                     clk,
	input  logic                     rst_n,
	input  logic                     op_valid,
	input  x86_exec_pkg::alu_op_e    op,
	input  x86_exec_pkg::data_size_e size,
	input  logic [`DATA_W-1:0]       a,
	input  logic [`DATA_W-1:0]       b,
	output logic                     result_valid,
	output logic [`DATA_W-1:0]       result,
	output logic                     dest_we,
	output logic [`DATA_W-1:0]       eflags
);

	logic [`DATA_W-1:0] alu_result;
	logic [`DATA_W-1:0] new_flags;
	logic               dest_we_next;

	// --------------------
	// Datapath
	// --------------------
	// DAA reads CF and AF straight from the architectural register
	// so back to back ops see the previous op's flags
	alu32 u_alu32 (
		.op           (op),
		.size         (size),
		.a            (a),
		.b            (b),
		.cf_in        (eflags[`CF_BIT]),
		.af_in        (eflags[`AF_BIT]),
		.alu_result   (alu_result),
		.new_flags    (new_flags),
		.dest_we_next (dest_we_next)
	);

	// Flags commit on the same edge as the result
	eflags_reg u_eflags_reg (
		.clk       (clk),
		.rst_n     (rst_n),
		.op_valid  (op_valid),
		.op        (op),
		.new_flags (new_flags),
		.eflags    (eflags)
	);

	// --------------------
	// Output registers
	// --------------------
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			result_valid <= 1'b0;
			result       <= '0;
			dest_we      <= 1'b0;
		end else begin
			// One cycle latency, no stall
			result_valid <= op_valid;
			// Result and write enable hold while idle
			if (op_valid) begin
				result  <= alu_result;
				dest_we <= dest_we_next;
			end
		end
	end

	// Two valid results in a row need two sampled ops in a row
	a_valid_pairs: assert property (
		@(posedge clk) disable iff (!rst_n)
		(result_valid && $past(result_valid)) |-> ($past(op_valid) && $past(op_valid, 2))
	) else $error("x86_exec: result_valid without matching op_valid");

endmodule

/* tb/tb_clock_gen.sv */
module tb_clock_gen (
	output logic clk,
	output logic rst_n
);
	timeunit 1ns;
	timeprecision 1ps;

	// 40 ns period
	localparam int HALF_PERIOD  = 20;
	localparam int RESET_CYCLES = 2;

	initial begin
		clk = 1'b0;
		forever #HALF_PERIOD clk = ~clk;
	end

	// Low across two rising edges, released on a falling edge
	initial begin
		rst_n = 1'b0;
		repeat (RESET_CYCLES) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;
	end

endmodule

/* tb/tb_x86_exec.sv */
`include "x86_exec_defines.svh"

module tb_x86_exec;
	timeunit 1ns;
	timeprecision 1ps;
	import x86_exec_pkg::*;

	localparam int TIMEOUT_CYCLES = 50;
	localparam int RANDOM_OPS     = 400;

	logic               clk;
	logic               rst_n;
	logic               op_valid;
	alu_op_e            op;
	data_size_e         size;
	logic [`DATA_W-1:0] a;
	logic [`DATA_W-1:0] b;
	logic               result_valid;
	logic [`DATA_W-1:0] result;
	logic               dest_we;
	logic [`DATA_W-1:0] eflags;

	// Expected outputs, oldest first
	logic [`DATA_W-1:0] exp_result_q[$];
	logic               exp_we_q[$];
	logic [`DATA_W-1:0] exp_flags_q[$];

	// Model's own EFLAGS copy
	logic [`DATA_W-1:0] model_flags;
	int                 error_count;

	tb_clock_gen u_clock_gen (
		.clk   (clk),
		.rst_n (rst_n)
	);

	x86_exec dut (
		.clk          (clk),
		.rst_n        (rst_n),
		.op_valid     (op_valid),
		.op           (op),
		.size         (size),
		.a            (a),
		.b            (b),
		.result_valid (result_valid),
		.result       (result),
		.dest_we      (dest_we),
		.eflags       (eflags)
	);

	// --------------------
	// Reference model
	// --------------------
	function automatic logic [31:0] mask_of(input data_size_e sz);
		case (sz)
			SIZE_8:  return 32'h0000_00ff;
			SIZE_16: return 32'h0000_ffff;
			default: return 32'hffff_ffff;
		endcase
	endfunction

	// Sign bit at the operand size
	function automatic logic sign_of(input logic [31:0] v, input data_size_e sz);
		case (sz)
			SIZE_8:  return v[7];
			SIZE_16: return v[15];
			default: return v[31];
		endcase
	endfunction

	function automatic logic [31:0] with_status(input logic [31:0] f, input logic of,
		input logic sf, input logic zf, input logic af, input logic pf, input logic cf);
		logic [31:0] n;
		n            = f;
		n[`OF_BIT]   = of;
		n[`SF_BIT]   = sf;
		n[`ZF_BIT]   = zf;
		n[`AF_BIT]   = af;
		n[`PF_BIT]   = pf;
		n[`CF_BIT]   = cf;
		return n;
	endfunction

	// Expected result and write enable, model_flags updated in place
	function automatic void model_exec(input alu_op_e o, input data_size_e sz,
		input logic [31:0] x, input logic [31:0] y, output logic [31:0] res, output logic we);
		logic [31:0] m;
		logic [32:0] wide;
		logic [7:0]  al;
		logic        lo_adj;
		logic        hi_adj;
		m   = mask_of(sz);
		we  = 1'b1;
		res = '0;
		case (o)
			OP_ADD: begin
				wide        = {1'b0, x & m} + {1'b0, y & m};
				res         = wide[31:0] & m;
				model_flags = with_status(model_flags,
					(sign_of(x, sz) == sign_of(y, sz)) && (sign_of(res, sz) != sign_of(x, sz)),
					sign_of(res, sz), res == '0,
					({1'b0, x[3:0]} + {1'b0, y[3:0]}) > 5'd15,
					~^res[7:0], wide > {1'b0, m});
			end
			// CMP is y minus x, no write back
			OP_CMP: begin
				res         = ((y & m) - (x & m)) & m;
				we          = 1'b0;
				model_flags = with_status(model_flags,
					(sign_of(y, sz) != sign_of(x, sz)) && (sign_of(res, sz) != sign_of(y, sz)),
					sign_of(res, sz), res == '0, y[3:0] < x[3:0],
					~^res[7:0], (y & m) < (x & m));
			end
			OP_OR, OP_AND: begin
				res         = ((o == OP_OR) ? (x | y) : (x & y)) & m;
				model_flags = with_status(model_flags, 1'b0, sign_of(res, sz), res == '0,
					1'b0, ~^res[7:0], 1'b0);
			end
			OP_NOT: res = ~x & m;
			// Packed BCD fix of the low byte, 8-bit flags
			OP_DAA: begin
				al     = x[7:0];
				lo_adj = (al[3:0] > 4'd9) || model_flags[`AF_BIT];
				hi_adj = (al > 8'h99) || model_flags[`CF_BIT];
				if (lo_adj)
					al = al + 8'h06;
				if (hi_adj)
					al = al + 8'h60;
				res         = {24'b0, al};
				model_flags = with_status(model_flags, 1'b0, al[7], al == 8'h00,
					lo_adj, ~^al, hi_adj);
			end
			OP_CLD: begin
				we                  = 1'b0;
				model_flags[`DF_BIT] = 1'b0;
			end
			default: begin
				we                  = 1'b0;
				model_flags[`DF_BIT] = 1'b1;
			end
		endcase
	endfunction

	// --------------------
	// Checks and stimulus
	// --------------------
	task automatic abort_run(input string why);
		$display("%s", why);
		$display("FAIL: see errors above");
		$fatal(1, "stopping at the first error");
	endtask

	task automatic check_val(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		if (got !== exp) begin
			error_count++;
			$display("FAIL %s: got 0x%08h, expected 0x%08h", name, got, exp);
			$display("FAIL: see errors above");
			$fatal(1, "stopping at the first error");
		end
	endtask

	// One op on the next falling edge, expectation queued first
	task automatic issue_op(input alu_op_e o, input data_size_e sz,
		input logic [31:0] x, input logic [31:0] y);
		logic [31:0] r;
		logic        w;
		@(negedge clk);
		model_exec(o, sz, x, y, r, w);
		exp_result_q.push_back(r);
		exp_we_q.push_back(w);
		exp_flags_q.push_back(model_flags);
		op_valid = 1'b1;
		op       = o;
		size     = sz;
		a        = x;
		b        = y;
	endtask

	task automatic idle_cycle();
		@(negedge clk);
		op_valid = 1'b0;
	endtask

	// BCD add, then DAA right behind it on the byte sum
	task automatic bcd_add(input logic [7:0] x, input logic [7:0] y);
		issue_op(OP_ADD, SIZE_8, {24'b0, x}, {24'b0, y});
		issue_op(OP_DAA, SIZE_8, {24'b0, x + y}, 32'h0);
	endtask

	task automatic drain_results();
		int n;
		n = 0;
		while (exp_result_q.size() != 0) begin
			@(negedge clk);
			n++;
			if (n > TIMEOUT_CYCLES)
				abort_run("timeout: no result arrived for the pending operations");
		end
	endtask

	// Compare on falling edges, outputs settled by then
	initial begin : compare_proc
		int          stall;
		logic [31:0] e_res;
		logic [31:0] e_flags;
		logic        e_we;
		stall = 0;
		forever begin
			@(negedge clk);
			if (rst_n === 1'b1 && result_valid === 1'b1) begin
				stall = 0;
				if (exp_result_q.size() == 0) begin
					abort_run("result_valid went high with no operation pending");
				end else begin
					e_res   = exp_result_q.pop_front();
					e_we    = exp_we_q.pop_front();
					e_flags = exp_flags_q.pop_front();
					check_val("result", result, e_res);
					check_val("dest_we", {31'b0, dest_we}, {31'b0, e_we});
					check_val("eflags", eflags, e_flags);
				end
			end else if (exp_result_q.size() != 0) begin
				stall++;
				if (stall > TIMEOUT_CYCLES)
					abort_run("timeout: no result arrived after an operation was issued");
			end
		end
	end

	initial begin : stimulus
		int         n;
		int         i;
		alu_op_e    r_op;
		data_size_e r_size;
		void'($urandom(42));
		error_count = 0;
		model_flags = `EFLAGS_RESET;
		op_valid    = 1'b0;
		op          = OP_ADD;
		size        = SIZE_32;
		a           = '0;
		b           = '0;

		n = 0;
		while (rst_n !== 1'b1) begin
			@(negedge clk);
			n++;
			if (n > TIMEOUT_CYCLES)
				abort_run("reset was never released");
		end

		// State right after reset
		@(negedge clk);
		check_val("result_valid", {31'b0, result_valid}, 32'h0);
		check_val("dest_we", {31'b0, dest_we}, 32'h0);
		check_val("result", result, 32'h0);
		check_val("eflags", eflags, `EFLAGS_RESET);

		// ADD, carry, overflow, zero and nibble carry per size
		issue_op(OP_ADD, SIZE_8, 32'h0000_00ff, 32'h0000_0001);
		issue_op(OP_ADD, SIZE_8, 32'h0000_007f, 32'h0000_0001);
		issue_op(OP_ADD, SIZE_8, 32'habcd_1280, 32'h1111_2280);
		issue_op(OP_ADD, SIZE_16, 32'h0000_ffff, 32'h0000_0001);
		issue_op(OP_ADD, SIZE_16, 32'h0001_7fff, 32'h0000_0001);
		issue_op(OP_ADD, SIZE_32, 32'hffff_ffff, 32'h0000_0001);
		issue_op(OP_ADD, SIZE_32, 32'h7fff_ffff, 32'h0000_0001);
		issue_op(OP_ADD, SIZE_32, 32'h8000_0000, 32'h8000_0000);
		issue_op(OP_ADD, SIZE_32, 32'h1234_5678, 32'h1111_1111);
		idle_cycle();

		// Logic ops, CF/AF/OF set first so the clear shows
		issue_op(OP_ADD, SIZE_32, 32'hffff_ffff, 32'h0000_0001);
		issue_op(OP_OR, SIZE_16, 32'h1234_f000, 32'h0000_0f0f);
		issue_op(OP_ADD, SIZE_8, 32'h0000_007f, 32'h0000_0001);
		issue_op(OP_AND, SIZE_32, 32'hf0f0_1234, 32'h8f0f_ff00);
		issue_op(OP_AND, SIZE_8, 32'h0000_00f0, 32'h0000_000f);
		issue_op(OP_ADD, SIZE_8, 32'h0000_00ff, 32'h0000_0001);
		issue_op(OP_NOT, SIZE_32, 32'h0f0f_1234, 32'h0000_0000);
		issue_op(OP_NOT, SIZE_8, 32'h1234_5600, 32'hffff_ffff);
		idle_cycle();

		// CMP borrow, equal, overflow, then DF set, kept, cleared
		issue_op(OP_CMP, SIZE_32, 32'h0000_0005, 32'h0000_0003);
		issue_op(OP_CMP, SIZE_16, 32'h0000_1234, 32'hffff_1234);
		issue_op(OP_CMP, SIZE_8, 32'h0000_0001, 32'h0000_0080);
		issue_op(OP_STD, SIZE_32, 32'h0000_0000, 32'h0000_0000);
		issue_op(OP_ADD, SIZE_32, 32'h0000_0010, 32'h0000_0020);
		issue_op(OP_NOT, SIZE_16, 32'h0000_00ff, 32'h0000_0000);
		issue_op(OP_OR, SIZE_8, 32'h0000_0000, 32'h0000_0000);
		issue_op(OP_CLD, SIZE_32, 32'h0000_0000, 32'h0000_0000);
		issue_op(OP_ADD, SIZE_32, 32'h0000_0001, 32'h0000_0002);
		idle_cycle();

		// BCD sums, 38+45, 99+01, 58+46, 09+08
		bcd_add(8'h38, 8'h45);
		bcd_add(8'h99, 8'h01);
		bcd_add(8'h58, 8'h46);
		bcd_add(8'h09, 8'h08);
		idle_cycle();

		// Random back-to-back ops
		for (i = 0; i < RANDOM_OPS; i++) begin
			r_op   = alu_op_e'(3'($urandom_range(7, 0)));
			r_size = data_size_e'(2'($urandom_range(2, 0)));
			issue_op(r_op, r_size, $urandom, $urandom);
		end
		idle_cycle();
		drain_results();

		if (error_count == 0) begin
			$display("PASS: all tests");
		end else begin
			$display("FAIL: see errors above");
		end
		$finish;
	end

endmodule

/* x86_exec.f */
+incdir+design
design/x86_exec_pkg.sv
design/alu_flag_logic.sv
design/alu_daa.sv
design/alu32.sv
design/eflags_reg.sv
design/x86_exec.sv
tb/tb_clock_gen.sv
tb/tb_x86_exec.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the x86_exec testbench with Verilator
cd "$(dirname "$0")" || exit 1

# Verdict comes from the testbench output
verilator --binary --timing --assert --timescale 1ns/1ps \
	--top-module tb_x86_exec -Mdir obj_dir -f x86_exec.f \
	&& ./obj_dir/Vtb_x86_exec | tee /dev/stderr | grep -qx "PASS: all tests" \
	&& echo "simulation passed" \
	|| { echo "simulation failed"; exit 1; }
